// File: verification/serv_testdata.hex
// Per test: name index, linear fetch flag, program length, program words,
// then expected stores as address/data pairs closed by ffffffff
00000004
// alu_ops
00000000 00000001 00000015
12300093 ff000113 002081b3 40208233 0020f2b3 0020e333 0020c3b3
0ff3f413 7000e493 fff0c513 abcde5b7 40302023 40402223 40502423
40602623 40702823 40802a23 40902c23 40a02e23 42b02023 0000006f
00000400 00000113 00000404 00000133 00000408 00000120
0000040c fffffff3 00000410 fffffed3 00000414 000000d3
00000418 00000723 0000041c fffffedc 00000420 abcde000 ffffffff
// load_word
00000001 00000001 00000008
41002083 4fc02103 40102023 40202223 4e102c23 4f802183 40302423 0000006f
00000400 0410ffff 00000404 04fcffff 000004f8 0410ffff 00000408 0410ffff ffffffff
// branch_jump
00000002 00000000 00000015
00500093 00500113 00700193 00208463 40102023 00209463 40302023
00308463 40202223 00309463 40102423 0080026f 40302623 40402423
00300293 00000313 00230313 fff28293 fe029ce3 40602623 0000006f
00000400 00000007 00000404 00000005 00000408 00000130 0000040c 00000006 ffffffff
// x0_and_unsupported
00000003 00000001 0000000a
05500013 40002023 02a00093 00108033 40002223 00109093 0000008b 4010c0b3 40102423 0000006f
00000400 00000000 00000404 00000000 00000408 0000002a ffffffff

// File: list.f
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/ctrl_if.sv
src/serv_ctrl.sv
src/serv_decode.sv
src/serv_alu.sv
src/serv_mem_if.sv
src/serv_rf_ram.sv
src/serv_top.sv
verification/serv_props.sv
verification/tb_serv_top.sv

// File: Bender.yml
package:
  name: serv_subset

sources:
  - src/rv_isa_pkg.sv
  - src/core_ctrl_pkg.sv
  - src/ctrl_if.sv
  - src/serv_ctrl.sv
  - src/serv_decode.sv
  - src/serv_alu.sv
  - src/serv_mem_if.sv
  - src/serv_rf_ram.sv
  - src/serv_top.sv
  - target: test
    files:
      - verification/serv_props.sv
      - verification/tb_serv_top.sv

// File: verification/tb_serv_top.sv
`timescale 1ns/1ps

module tb_serv_top;

   localparam logic [31:0] RESET_PC   = 32'h0000_0100;
   localparam logic [31:0] DMEM_BASE  = 32'h0000_0400;
   localparam logic [31:0] JAL_SELF   = 32'h0000_006f;
   localparam logic [31:0] MARKER     = 32'hffff_ffff;
   localparam logic [31:0] SEED       = 32'h910b_0ecf;
   localparam int          IMEM_WORDS = 64;
   localparam int          DMEM_WORDS = 64;

   logic        clk;
   logic        i_reset;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic [31:0] o_dbus_adr;
   logic [31:0] o_dbus_dat;
   logic        o_dbus_we;
   logic        o_dbus_cyc;
   logic [31:0] i_dbus_rdt;
   logic        i_dbus_ack;

   logic [31:0] tdata [0:255];
   logic [31:0] imem [0:IMEM_WORDS-1];
   logic [31:0] dmem [0:DMEM_WORDS-1];
   logic [63:0] exp_q [$];
   string       cur_name;
   logic        linear;
   logic        first_fetch;
   logic        test_done;
   logic [31:0] prev_fetch;
   logic [31:0] ibus_rng;
   logic [31:0] dbus_rng;
   logic        ibus_busy;
   logic        dbus_busy;
   int          ibus_wait;
   int          dbus_wait;
   int          test_errors;
   int          watchdog_ns;

   serv_top #(
      .RESET_PC (RESET_PC)
   ) i_dut (
      .clk        (clk),
      .i_reset    (i_reset),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Initial data memory contents, unique per word address
   function automatic logic [31:0] fill_word(input logic [31:0] adr);
      return {adr[15:0], ~adr[31:16]};
   endfunction

   function automatic string test_name(input logic [31:0] idx);
      case (idx)
         32'd0:   return "alu_ops";
         32'd1:   return "load_word";
         32'd2:   return "branch_jump";
         32'd3:   return "x0_and_unsupported";
         default: return "unnamed";
      endcase
   endfunction

   function automatic logic [31:0] fetch_word(input logic [31:0] adr);
      if ((adr >= RESET_PC) && (adr < RESET_PC + 4 * IMEM_WORDS)) begin
         return imem[(adr - RESET_PC) >> 2];
      end
      return JAL_SELF;
   endfunction

   task automatic check_fetch(input logic [31:0] adr);
      if (first_fetch) begin
         assert (adr == RESET_PC) else begin
            $display("FAILED %s first fetch: expected %08h, actual %08h",
                     cur_name, RESET_PC, adr);
            test_errors++;
         end
         first_fetch = 1'b0;
      end else if (adr == prev_fetch) begin
         // Self-jump closes the program
         test_done = 1'b1;
      end else if (linear) begin
         assert (adr == prev_fetch + 32'd4) else begin
            $display("FAILED %s fetch after %08h: expected %08h, actual %08h",
                     cur_name, prev_fetch, prev_fetch + 32'd4, adr);
            test_errors++;
         end
      end
      assert ((adr >= RESET_PC) && (adr < RESET_PC + 4 * IMEM_WORDS) && (adr[1:0] == 2'b00))
      else begin
         $display("%s: instruction fetch outside program memory at %08h", cur_name, adr);
         test_errors++;
      end
      prev_fetch = adr;
   endtask

   task automatic check_data_access(input logic [31:0] adr, input logic [31:0] dat,
                                    input logic we);
      logic [63:0] rec;
      assert ((adr & 32'hffff_ff03) == DMEM_BASE) else begin
         $display("%s: data access outside data memory at %08h", cur_name, adr);
         test_errors++;
      end
      if (we) begin
         assert (exp_q.size() != 0) else begin
            $display("%s: unexpected store of %08h to %08h", cur_name, dat, adr);
            test_errors++;
         end
         if (exp_q.size() != 0) begin
            rec = exp_q.pop_front();
            assert (adr == rec[63:32]) else begin
               $display("FAILED %s store address: expected %08h, actual %08h",
                        cur_name, rec[63:32], adr);
               test_errors++;
            end
            assert (dat == rec[31:0]) else begin
               $display("FAILED %s store data at %08h: expected %08h, actual %08h",
                        cur_name, rec[63:32], rec[31:0], dat);
               test_errors++;
            end
         end
         dmem[adr[7:2]] = dat;
      end
   endtask

   // Instruction memory, acknowledge after 0 to 3 cycles
   always @(negedge clk) begin
      if (i_reset) begin
         i_ibus_ack <= 1'b0;
         ibus_busy = 1'b0;
      end else if (i_ibus_ack) begin
         i_ibus_ack <= 1'b0;
         ibus_busy = 1'b0;
      end else if (o_ibus_cyc) begin
         if (!ibus_busy) begin
            ibus_busy = 1'b1;
            ibus_rng  = xorshift32(ibus_rng);
            ibus_wait = ibus_rng[1:0];
            check_fetch(o_ibus_adr);
         end
         if (ibus_wait == 0) begin
            i_ibus_rdt <= fetch_word(o_ibus_adr);
            i_ibus_ack <= 1'b1;
         end else begin
            ibus_wait = ibus_wait - 1;
         end
      end
   end

   // Data memory
   always @(negedge clk) begin
      if (i_reset) begin
         i_dbus_ack <= 1'b0;
         dbus_busy = 1'b0;
      end else if (i_dbus_ack) begin
         i_dbus_ack <= 1'b0;
         dbus_busy = 1'b0;
      end else if (o_dbus_cyc) begin
         if (!dbus_busy) begin
            dbus_busy = 1'b1;
            dbus_rng  = xorshift32(dbus_rng);
            dbus_wait = dbus_rng[1:0];
            check_data_access(o_dbus_adr, o_dbus_dat, o_dbus_we);
         end
         if (dbus_wait == 0) begin
            i_dbus_rdt <= dmem[o_dbus_adr[7:2]];
            i_dbus_ack <= 1'b1;
         end else begin
            dbus_wait = dbus_wait - 1;
         end
      end
   end

   initial begin
      wait (watchdog_ns != 0);
      #(watchdog_ns);
      $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
      $display("Verification failed");
      $finish;
   end

   initial begin
      int num_tests;
      int ptr;
      int prog_len;
      int tests_failed;
      int total_errors;
      clk          = 1'b0;
      i_reset      = 1'b1;
      i_ibus_rdt   = '0;
      i_ibus_ack   = 1'b0;
      i_dbus_rdt   = '0;
      i_dbus_ack   = 1'b0;
      ibus_rng     = SEED;
      dbus_rng     = xorshift32(SEED);
      ibus_busy    = 1'b0;
      dbus_busy    = 1'b0;
      first_fetch  = 1'b1;
      test_done    = 1'b0;
      linear       = 1'b0;
      prev_fetch   = '0;
      test_errors  = 0;
      watchdog_ns  = 0;
      tests_failed = 0;
      total_errors = 0;
      $readmemh("verification/serv_testdata.hex", tdata);
      num_tests = 0;
      assert (!$isunknown(tdata[0]) && (tdata[0] != 0)) else begin
         $display("The test data file could not be read");
         total_errors++;
      end
      if (total_errors == 0) begin
         num_tests = tdata[0];
      end
      watchdog_ns = num_tests * IMEM_WORDS * 140 * 40;
      ptr = 1;
      for (int t = 0; t < num_tests; t++) begin
         @(negedge clk);
         i_reset <= 1'b1;
         repeat (4) @(negedge clk);
         // Core is held in reset while the next program is loaded
         cur_name = test_name(tdata[ptr]);
         linear   = tdata[ptr + 1][0];
         prog_len = tdata[ptr + 2];
         ptr      = ptr + 3;
         for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < prog_len) ? tdata[ptr + i] : JAL_SELF;
         end
         ptr = ptr + prog_len;
         exp_q.delete();
         while ((tdata[ptr] !== MARKER) && (ptr < 254)) begin
            exp_q.push_back({tdata[ptr], tdata[ptr + 1]});
            ptr = ptr + 2;
         end
         ptr = ptr + 1;
         for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(DMEM_BASE + 4 * i);
         end
         first_fetch = 1'b1;
         test_done   = 1'b0;
         test_errors = 0;
         i_reset <= 1'b0;
         while (!test_done) @(posedge clk);
         assert (exp_q.size() == 0) else begin
            $display("%s: %0d expected stores never appeared on the data bus",
                     cur_name, exp_q.size());
            test_errors++;
         end
         if (test_errors == 0) begin
            $display("Test %s: ok", cur_name);
         end else begin
            $display("Test %s: %0d errors", cur_name, test_errors);
            tests_failed++;
         end
         total_errors = total_errors + test_errors;
      end
      $display("Tests run: %0d, tests with errors: %0d, errors: %0d",
               num_tests, tests_failed, total_errors);
      if (total_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: verification/serv_props.sv
`timescale 1ns/1ps

module serv_props (
   input logic        clk,
   input logic        i_reset,
   input logic [31:0] o_ibus_adr,
   input logic        o_ibus_cyc,
   input logic        i_ibus_ack,
   input logic [31:0] o_dbus_adr,
   input logic [31:0] o_dbus_dat,
   input logic        o_dbus_we,
   input logic        o_dbus_cyc,
   input logic        i_dbus_ack
);

   // Requests are held with a stable address until acknowledged
   ibus_hold: assert property (@(posedge clk) disable iff (i_reset)
      (o_ibus_cyc && !i_ibus_ack) |=> (o_ibus_cyc && $stable(o_ibus_adr)))
      else $error("Instruction request dropped or changed before its acknowledge");

   dbus_hold: assert property (@(posedge clk) disable iff (i_reset)
      (o_dbus_cyc && !i_dbus_ack) |=>
      (o_dbus_cyc && $stable(o_dbus_adr) && $stable(o_dbus_dat) && $stable(o_dbus_we)))
      else $error("Data request dropped or changed before its acknowledge");

   bus_exclusive: assert property (@(posedge clk) !(o_ibus_cyc && o_dbus_cyc))
      else $error("Instruction and data requests active in the same cycle");

   reset_idle: assert property (@(posedge clk) i_reset |=> (!o_ibus_cyc && !o_dbus_cyc))
      else $error("Bus request active right after reset");

endmodule

bind serv_top serv_props i_props (.*);

// File: src/serv_top.sv
`timescale 1ns/1ps

module serv_top
   import rv_isa_pkg::*;
   import core_ctrl_pkg::*;
#(
   parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
   input  logic            clk,
   input  logic            i_reset,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_ibus_cyc,
   input  logic [XLEN-1:0] i_ibus_rdt,
   input  logic            i_ibus_ack,
   output logic [XLEN-1:0] o_dbus_adr,
   output logic [XLEN-1:0] o_dbus_dat,
   output logic            o_dbus_we,
   output logic            o_dbus_cyc,
   input  logic [XLEN-1:0] i_dbus_rdt,
   input  logic            i_dbus_ack
);

   phase_e     phase;
   logic [4:0] cnt;
   logic       cnt_en;
   logic       cnt0;
   logic       alu_eq;
   logic       alu_bit;
   logic       link_bit;
   logic       mem_bit;
   logic       dbus_done;
   logic       rs1_bit;
   logic       rs2_bit;
   logic       rf_wr_en;

   ctrl_if ctl ();

   assign cnt0 = (cnt == 5'd0);

   // Loads write back in PH_LOAD, all other writers in PH_EXEC
   assign rf_wr_en = (phase == PH_LOAD) | ((phase == PH_EXEC) & !ctl.is_load);

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl (
      .clk         (clk),
      .i_reset     (i_reset),
      .io_ctl      (ctl),
      .i_alu_eq    (alu_eq),
      .i_ibus_ack  (i_ibus_ack),
      .o_ibus_adr  (o_ibus_adr),
      .o_ibus_cyc  (o_ibus_cyc),
      .i_dbus_done (dbus_done),
      .o_phase     (phase),
      .o_cnt       (cnt),
      .o_cnt_en    (cnt_en),
      .o_cnt_done  (),
      .o_link_bit  (link_bit)
   );

   serv_decode decode (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_cyc (o_ibus_cyc),
      .i_cnt      (cnt),
      .i_cnt_en   (cnt_en),
      .io_ctl     (ctl)
   );

   serv_alu alu (
      .clk      (clk),
      .i_reset  (i_reset),
      .io_ctl   (ctl),
      .i_rs1    (rs1_bit),
      .i_rs2    (rs2_bit),
      .i_cnt_en (cnt_en),
      .i_cnt0   (cnt0),
      .o_rd_bit (alu_bit),
      .o_eq     (alu_eq)
   );

   serv_mem_if mem_if (
      .clk        (clk),
      .i_reset    (i_reset),
      .io_ctl     (ctl),
      .i_phase    (phase),
      .i_cnt_en   (cnt_en),
      .i_alu_bit  (alu_bit),
      .i_rs2      (rs2_bit),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_done     (dbus_done),
      .o_rd_bit   (mem_bit)
   );

   serv_rf_ram rf (
      .clk        (clk),
      .i_reset    (i_reset),
      .io_ctl     (ctl),
      .i_cnt      (cnt),
      .i_wr_en    (rf_wr_en),
      .i_alu_bit  (alu_bit),
      .i_link_bit (link_bit),
      .i_mem_bit  (mem_bit),
      .o_rs1      (rs1_bit),
      .o_rs2      (rs2_bit)
   );

endmodule

// File: src/serv_rf_ram.sv
`timescale 1ns/1ps

module serv_rf_ram
   import rv_isa_pkg::*;
   import core_ctrl_pkg::*;
(
   input  logic       clk,
   input  logic       i_reset,
   ctrl_if.rf         io_ctl,
   input  logic [4:0] i_cnt,
   input  logic       i_wr_en,
   input  logic       i_alu_bit,
   input  logic       i_link_bit,
   input  logic       i_mem_bit,
   output logic       o_rs1,
   output logic       o_rs2
);

   // x0 has no storage
   logic [XLEN-1:0] regs [1:31];
   logic            rd_bit;
   logic            wen;

   always_comb begin
      case (io_ctl.rd_src)
         RD_ALU:  rd_bit = i_alu_bit;
         RD_IMM:  rd_bit = io_ctl.imm_bit;
         RD_LINK: rd_bit = i_link_bit;
         RD_MEM:  rd_bit = i_mem_bit;
         default: rd_bit = 1'b0;
      endcase
   end

   assign wen = i_wr_en & io_ctl.rd_wen & (io_ctl.rd_addr != 5'd0) & !i_reset;

   always_ff @(posedge clk) begin
      if (wen) begin
         regs[io_ctl.rd_addr][i_cnt] <= rd_bit;
      end
   end

   assign o_rs1 = (io_ctl.rs1_addr == 5'd0) ? 1'b0 : regs[io_ctl.rs1_addr][i_cnt];
   assign o_rs2 = (io_ctl.rs2_addr == 5'd0) ? 1'b0 : regs[io_ctl.rs2_addr][i_cnt];

endmodule

// File: src/serv_mem_if.sv
`timescale 1ns/1ps

module serv_mem_if
   import rv_isa_pkg::*;
   import core_ctrl_pkg::*;
(
   input  logic            clk,
   input  logic            i_reset,
   ctrl_if.mem             io_ctl,
   input  phase_e          i_phase,
   input  logic            i_cnt_en,
   input  logic            i_alu_bit,
   input  logic            i_rs2,
   output logic [XLEN-1:0] o_dbus_adr,
   output logic [XLEN-1:0] o_dbus_dat,
   output logic            o_dbus_we,
   output logic            o_dbus_cyc,
   input  logic [XLEN-1:0] i_dbus_rdt,
   input  logic            i_dbus_ack,
   output logic            o_done,
   output logic            o_rd_bit
);

   logic [XLEN-1:0] adr_q;
   logic [XLEN-1:0] dat_q;
   logic            cyc_q;
   logic            mem_op;

   assign mem_op = io_ctl.is_load | io_ctl.is_store;
   assign o_done = cyc_q & i_dbus_ack;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         cyc_q <= 1'b0;
      end else if (cyc_q) begin
         if (i_dbus_ack) begin
            cyc_q <= 1'b0;
         end
      end else if (i_phase == PH_BUS) begin
         cyc_q <= 1'b1;
      end
   end

   // Store data and load data share one shift register
   always_ff @(posedge clk) begin
      if (i_cnt_en & (i_phase == PH_EXEC) & mem_op) begin
         adr_q <= {i_alu_bit, adr_q[XLEN-1:1]};
         dat_q <= {i_rs2, dat_q[XLEN-1:1]};
      end else if (o_done & io_ctl.is_load) begin
         dat_q <= i_dbus_rdt;
      end else if (i_cnt_en & (i_phase == PH_LOAD)) begin
         dat_q <= {1'b0, dat_q[XLEN-1:1]};
      end
   end

   assign o_dbus_adr = adr_q;
   assign o_dbus_dat = dat_q;
   assign o_dbus_we  = io_ctl.is_store;
   assign o_dbus_cyc = cyc_q;
   assign o_rd_bit   = dat_q[0];

endmodule

// File: src/serv_alu.sv
`timescale 1ns/1ps

module serv_alu
   import core_ctrl_pkg::*;
(
   input  logic clk,
   input  logic i_reset,
   ctrl_if.alu  io_ctl,
   input  logic i_rs1,
   input  logic i_rs2,
   input  logic i_cnt_en,
   input  logic i_cnt0,
   output logic o_rd_bit,
   output logic o_eq
);

   logic op_b;
   logic b_in;
   logic carry_q;
   logic carry_in;
   logic sum;
   logic eq_q;

   assign op_b = io_ctl.op_b_imm ? io_ctl.imm_bit : i_rs2;
   assign b_in = op_b ^ (io_ctl.alu_op == ALU_SUB);

   // Two's complement subtract starts with carry set
   assign carry_in = i_cnt0 ? (io_ctl.alu_op == ALU_SUB) : carry_q;
   assign sum      = i_rs1 ^ b_in ^ carry_in;

   // Includes the current bit, so it is complete at cnt_done
   assign o_eq = (i_cnt0 | eq_q) & (i_rs1 == i_rs2);

   always_comb begin
      case (io_ctl.alu_op)
         ALU_AND: o_rd_bit = i_rs1 & op_b;
         ALU_OR:  o_rd_bit = i_rs1 | op_b;
         ALU_XOR: o_rd_bit = i_rs1 ^ op_b;
         default: o_rd_bit = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= (i_rs1 & b_in) | (i_rs1 & carry_in) | (b_in & carry_in);
         eq_q    <= o_eq;
      end
   end

endmodule

// File: src/serv_decode.sv
`timescale 1ns/1ps

module serv_decode
   import rv_isa_pkg::*;
   import core_ctrl_pkg::*;
(
   input  logic            clk,
   input  logic            i_reset,
   input  logic [XLEN-1:0] i_ibus_rdt,
   input  logic            i_ibus_ack,
   input  logic            i_ibus_cyc,
   input  logic [4:0]      i_cnt,
   input  logic            i_cnt_en,
   ctrl_if.dec             io_ctl
);

   logic [XLEN-1:0] instr;
   logic            decode_q;
   logic [XLEN-1:0] imm_full;
   logic [XLEN-1:0] imm_q;
   opcode_e         opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;

   assign opcode = opcode_e'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   always_ff @(posedge clk) begin
      if (i_reset) begin
         instr    <= '0;
         decode_q <= 1'b0;
      end else begin
         decode_q <= i_ibus_cyc & i_ibus_ack;
         if (i_ibus_cyc & i_ibus_ack) begin
            instr <= i_ibus_rdt;
         end
      end
   end

   always_comb begin
      case (opcode)
         OP_LUI:    imm_full = {instr[31:12], 12'd0};
         OP_JAL:    imm_full = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
         OP_BRANCH: imm_full = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
         OP_STORE:  imm_full = {{21{instr[31]}}, instr[30:25], instr[11:7]};
         default:   imm_full = {{21{instr[31]}}, instr[30:20]};
      endcase
   end

   // Reloaded before every pass, so JUMP sees the immediate from bit 0 again
   always_ff @(posedge clk) begin
      if (decode_q | (i_cnt_en & (i_cnt == 5'd31))) begin
         imm_q <= imm_full;
      end else if (i_cnt_en) begin
         imm_q <= {imm_q[XLEN-1], imm_q[XLEN-1:1]};
      end
   end

   assign io_ctl.imm_bit  = imm_q[0];
   assign io_ctl.rs1_addr = instr[19:15];
   assign io_ctl.rs2_addr = instr[24:20];
   assign io_ctl.rd_addr  = instr[11:7];

   always_comb begin
      io_ctl.alu_op    = ALU_ADD;
      io_ctl.op_b_imm  = 1'b0;
      io_ctl.rd_src    = RD_NONE;
      io_ctl.rd_wen    = 1'b0;
      io_ctl.is_branch = 1'b0;
      io_ctl.branch_ne = 1'b0;
      io_ctl.is_jal    = 1'b0;
      io_ctl.is_load   = 1'b0;
      io_ctl.is_store  = 1'b0;
      case (opcode)
         OP_LUI: begin
            io_ctl.rd_src = RD_IMM;
            io_ctl.rd_wen = 1'b1;
         end
         OP_JAL: begin
            io_ctl.is_jal = 1'b1;
            io_ctl.rd_src = RD_LINK;
            io_ctl.rd_wen = 1'b1;
         end
         OP_BRANCH: begin
            if ((funct3 == FUNCT3_BEQ) | (funct3 == FUNCT3_BNE)) begin
               io_ctl.is_branch = 1'b1;
               io_ctl.branch_ne = (funct3 == FUNCT3_BNE);
               io_ctl.alu_op    = ALU_SUB;
            end
         end
         OP_LOAD: begin
            if (funct3 == FUNCT3_LW) begin
               io_ctl.is_load  = 1'b1;
               io_ctl.op_b_imm = 1'b1;
               io_ctl.rd_src   = RD_MEM;
               io_ctl.rd_wen   = 1'b1;
            end
         end
         OP_STORE: begin
            if (funct3 == FUNCT3_LW) begin
               io_ctl.is_store = 1'b1;
               io_ctl.op_b_imm = 1'b1;
            end
         end
         OP_IMM, OP_REG: begin
            if ((opcode == OP_IMM) | (funct7 == FUNCT7_BASE) |
                ((funct7 == FUNCT7_SUB) & (funct3 == FUNCT3_ADD))) begin
               io_ctl.op_b_imm = (opcode == OP_IMM);
               io_ctl.rd_src   = RD_ALU;
               io_ctl.rd_wen   = 1'b1;
               case (funct3)
                  FUNCT3_ADD: begin
                     if ((opcode == OP_REG) & (funct7 == FUNCT7_SUB)) begin
                        io_ctl.alu_op = ALU_SUB;
                     end
                  end
                  FUNCT3_XOR: io_ctl.alu_op = ALU_XOR;
                  FUNCT3_OR:  io_ctl.alu_op = ALU_OR;
                  FUNCT3_AND: io_ctl.alu_op = ALU_AND;
                  default: begin
                     // Shifts and SLT are not implemented
                     io_ctl.rd_src = RD_NONE;
                     io_ctl.rd_wen = 1'b0;
                  end
               endcase
            end
         end
         default: ;
      endcase
   end

endmodule

// File: src/serv_ctrl.sv
`timescale 1ns/1ps

module serv_ctrl
   import rv_isa_pkg::*;
   import core_ctrl_pkg::*;
#(
   parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
   input  logic            clk,
   input  logic            i_reset,
   ctrl_if.ctrl            io_ctl,
   input  logic            i_alu_eq,
   input  logic            i_ibus_ack,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_ibus_cyc,
   input  logic            i_dbus_done,
   output phase_e          o_phase,
   output logic [4:0]      o_cnt,
   output logic            o_cnt_en,
   output logic            o_cnt_done,
   output logic            o_link_bit
);

   phase_e          phase;
   logic [4:0]      cnt;
   logic            ibus_cyc_q;
   logic            decode_q;
   logic [XLEN-1:0] pc;
   logic [1:0]      pc_carry;
   logic            pc_en;
   logic            add_b;
   logic            add_c;
   logic [1:0]      carry_in;
   logic [2:0]      pc_total;
   logic            mem_op;
   logic            take_jump;

   assign o_cnt_en   = (phase == PH_EXEC) | (phase == PH_LOAD) | (phase == PH_JUMP);
   assign o_cnt_done = o_cnt_en & (cnt == 5'd31);
   assign pc_en      = (phase == PH_EXEC) | (phase == PH_JUMP);

   // EXEC adds 4; JUMP adds imm - 4 since the PC was already incremented
   assign add_b    = (phase == PH_JUMP) ? io_ctl.imm_bit : (cnt == 5'd2);
   assign add_c    = (phase == PH_JUMP) & (cnt >= 5'd2);
   assign carry_in = (cnt == 5'd0) ? 2'd0 : pc_carry;
   assign pc_total = {2'b00, pc[0]} + {2'b00, add_b} + {2'b00, add_c} + {1'b0, carry_in};

   // pc+4 bit while in EXEC
   assign o_link_bit = pc_total[0];

   assign mem_op    = io_ctl.is_load | io_ctl.is_store;
   assign take_jump = io_ctl.is_jal | (io_ctl.is_branch & (i_alu_eq ^ io_ctl.branch_ne));

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase      <= PH_FETCH;
         cnt        <= 5'd0;
         ibus_cyc_q <= 1'b0;
         decode_q   <= 1'b0;
         pc         <= RESET_PC;
         pc_carry   <= 2'd0;
      end else begin
         if (o_cnt_en) begin
            cnt <= cnt + 5'd1;
         end
         if (pc_en) begin
            pc       <= {pc_total[0], pc[XLEN-1:1]};
            pc_carry <= pc_total[2:1];
         end
         case (phase)
            PH_FETCH: begin
               if (ibus_cyc_q) begin
                  if (i_ibus_ack) begin
                     ibus_cyc_q <= 1'b0;
                     decode_q   <= 1'b1;
                  end
               end else if (decode_q) begin
                  decode_q <= 1'b0;
                  phase    <= PH_EXEC;
               end else begin
                  // First fetch after reset
                  ibus_cyc_q <= 1'b1;
               end
            end
            PH_EXEC: begin
               if (o_cnt_done) begin
                  if (mem_op) begin
                     phase <= PH_BUS;
                  end else if (take_jump) begin
                     phase <= PH_JUMP;
                  end else begin
                     phase      <= PH_FETCH;
                     ibus_cyc_q <= 1'b1;
                  end
               end
            end
            PH_BUS: begin
               if (i_dbus_done) begin
                  if (io_ctl.is_load) begin
                     phase <= PH_LOAD;
                  end else begin
                     phase      <= PH_FETCH;
                     ibus_cyc_q <= 1'b1;
                  end
               end
            end
            default: begin
               if (o_cnt_done) begin
                  phase      <= PH_FETCH;
                  ibus_cyc_q <= 1'b1;
               end
            end
         endcase
      end
   end

   assign o_phase    = phase;
   assign o_cnt      = cnt;
   assign o_ibus_cyc = ibus_cyc_q;
   assign o_ibus_adr = pc;

endmodule

// File: src/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if
   import core_ctrl_pkg::*;
   ();

   alu_op_e    alu_op;
   logic       op_b_imm;
   rd_src_e    rd_src;
   logic       rd_wen;
   logic [4:0] rs1_addr;
   logic [4:0] rs2_addr;
   logic [4:0] rd_addr;
   logic       is_branch;
   logic       branch_ne;
   logic       is_jal;
   logic       is_load;
   logic       is_store;
   logic       imm_bit;

   modport dec (output alu_op, op_b_imm, rd_src, rd_wen, rs1_addr, rs2_addr, rd_addr,
                       is_branch, branch_ne, is_jal, is_load, is_store, imm_bit);

   modport alu (input alu_op, op_b_imm, imm_bit);

   modport ctrl (input is_branch, branch_ne, is_jal, is_load, is_store, imm_bit);

   modport mem (input is_load, is_store);

   modport rf (input rs1_addr, rs2_addr, rd_addr, rd_wen, rd_src, imm_bit);

endinterface

// File: src/core_ctrl_pkg.sv
package core_ctrl_pkg;

   // Controller phases, one instruction walks through a subset of these
   typedef enum logic [2:0] {
      PH_FETCH,
      PH_EXEC,
      PH_BUS,
      PH_LOAD,
      PH_JUMP
   } phase_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   // Source of the serial rd bit
   typedef enum logic [2:0] {
      RD_ALU,
      RD_IMM,
      RD_LINK,
      RD_MEM,
      RD_NONE
   } rd_src_e;

endpackage

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

   localparam int XLEN = 32;

   // Major opcodes of the supported RV32I subset
   typedef enum logic [6:0] {
      OP_LUI    = 7'b0110111,
      OP_JAL    = 7'b1101111,
      OP_BRANCH = 7'b1100011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_IMM    = 7'b0010011,
      OP_REG    = 7'b0110011
   } opcode_e;

   // Register and immediate ALU ops
   localparam logic [2:0] FUNCT3_ADD = 3'b000;
   localparam logic [2:0] FUNCT3_XOR = 3'b100;
   localparam logic [2:0] FUNCT3_OR  = 3'b110;
   localparam logic [2:0] FUNCT3_AND = 3'b111;

   localparam logic [2:0] FUNCT3_BEQ = 3'b000;
   localparam logic [2:0] FUNCT3_BNE = 3'b001;
   // Word access, SW uses the same code
   localparam logic [2:0] FUNCT3_LW  = 3'b010;

   localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
   localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

endpackage
